//--- design/id_alloc.sv
`timescale 1ns/100ps
`include "rv_decode_settings.svh"

module id_alloc (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         fetch_valid,
    input  logic                         is_br,
    input  logic                         is_ld,
    input  logic                         is_st,
    input  logic                         queue_full,
    input  logic                         commit_valid,
    input  logic                         commit_br,
    input  logic                         commit_ld,
    input  logic                         commit_st,
    input  logic                         redirect,
    input  logic [$clog2(`OP_SLOTS)-1:0] redirect_op_id,
    input  logic [$clog2(`BR_SLOTS)-1:0] redirect_br_id,
    input  logic [$clog2(`LD_SLOTS)-1:0] redirect_ld_id,
    input  logic [$clog2(`ST_SLOTS)-1:0] redirect_st_id,
    output logic                         fetch_ready,
    output logic                         push,
    output logic [$clog2(`OP_SLOTS)-1:0] op_id,
    output logic [$clog2(`BR_SLOTS)-1:0] br_id,
    output logic [$clog2(`LD_SLOTS)-1:0] ld_id,
    output logic [$clog2(`ST_SLOTS)-1:0] st_id
);
    localparam int ID_W  = $clog2(`OP_SLOTS);   // op pool is the widest
    localparam int CNT_W = ID_W + 1;

    // pool order: op, branch, load, store
    logic [3:0]           want;     // pools the current instruction draws from
    logic [3:0]           rel;      // pools this cycle's commit returns to
    logic [3:0]           free;
    logic [3:0][ID_W-1:0] red_id;   // next IDs after a redirect
    logic [3:0][ID_W-1:0] nid;

    assign want = {is_st, is_ld, is_br, 1'b1};
    assign rel  = {commit_st, commit_ld, commit_br, 1'b1} & {4{commit_valid}};

    assign red_id[0] = redirect_op_id + 1'b1;   // redirecting op stays in flight
    assign red_id[1] = ID_W'(redirect_br_id);
    assign red_id[2] = ID_W'(redirect_ld_id);
    assign red_id[3] = ID_W'(redirect_st_id);

    assign fetch_ready = !redirect && !queue_full && &(free | ~want);
    assign push        = fetch_valid && fetch_ready;

    assign op_id = nid[0];
    assign br_id = nid[1][$clog2(`BR_SLOTS)-1:0];
    assign ld_id = nid[2][$clog2(`LD_SLOTS)-1:0];
    assign st_id = nid[3][$clog2(`ST_SLOTS)-1:0];

    for (genvar p = 0; p < 4; p++) begin : g_pool
        localparam int SIZE = p == 0 ? `OP_SLOTS : p == 1 ? `BR_SLOTS :
                              p == 2 ? `LD_SLOTS : `ST_SLOTS;
        localparam logic [ID_W-1:0] MASK = ID_W'(SIZE - 1);

        logic [ID_W-1:0]  next_id;
        logic [CNT_W-1:0] count;    // IDs in flight
        logic [ID_W-1:0]  rewind;   // IDs handed out past the redirect point

        assign nid[p]  = next_id;
        assign free[p] = count < CNT_W'(SIZE);
        assign rewind  = (next_id - red_id[p]) & MASK;

        always_ff @(posedge clk) begin
            if (rst) begin
                next_id <= '0;
                count   <= '0;
            end else if (redirect) begin
                next_id <= red_id[p] & MASK;
                count   <= count - CNT_W'(rewind) - CNT_W'(rel[p]);
            end else begin
                if (push && want[p]) begin
                    next_id <= (next_id + 1'b1) & MASK;
                end
                count <= count + CNT_W'(push && want[p]) - CNT_W'(rel[p]);
            end
        end

        assert property (@(posedge clk) disable iff (rst) count <= CNT_W'(SIZE))
            else $error("id_alloc: pool %0d over capacity", p);
    end

endmodule

//--- design/imm_extract.sv
`timescale 1ns/100ps

module imm_extract (
    input  logic [31:0]             ir,
    input  rv_decode_pkg::imm_fmt_t fmt,
    output logic [63:0]             imm
);
    import rv_decode_pkg::*;

    always_comb begin
        case (fmt)
            IMM_I:   imm = {{53{ir[31]}}, ir[30:20]};
            IMM_S:   imm = {{53{ir[31]}}, ir[30:25], ir[11:7]};
            IMM_B:   imm = {{52{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
            IMM_U:   imm = {{32{ir[31]}}, ir[31:12], 12'd0};
            IMM_J:   imm = {{44{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
            default: imm = 64'd0;   // register-only formats
        endcase
    end

endmodule

//--- design/inst_classify.sv
`timescale 1ns/100ps

module inst_classify (
    input  logic [31:0]             ir,
    output rv_decode_pkg::fu_t      fu,
    output rv_decode_pkg::alu_fn_t  alu_fn,
    output logic [2:0]              funct3,
    output logic                    word,
    output logic                    use_pc,
    output logic                    use_imm,
    output logic [4:0]              rs1,
    output logic [4:0]              rs2,
    output logic [4:0]              rd,
    output rv_decode_pkg::imm_fmt_t fmt,
    output logic                    is_br,
    output logic                    is_ld,
    output logic                    is_st
);
    import rv_decode_pkg::*;

    opcode_t    opc;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       legal;      // function fields valid for this opcode
    logic       has_rs1;
    logic       has_rs2;
    logic       has_rd;

    // alt selects SUB over ADD and SRA over SRL
    function automatic alu_fn_t f3_fn(input logic [2:0] f, input logic alt);
        case (f)
            3'b000:  return alt ? SUB : ADD;
            3'b001:  return SLL;
            3'b010:  return SLT;
            3'b011:  return SLTU;
            3'b100:  return XOR;
            3'b101:  return alt ? SRA : SRL;
            3'b110:  return OR;
            default: return AND;
        endcase
    endfunction

    assign opc = opcode_t'(ir[6:2]);
    assign f3  = ir[14:12];
    assign f7  = ir[31:25];

    always_comb begin
        legal   = 1'b0;
        fu      = FU_ALU;
        alu_fn  = ADD;
        funct3  = 3'd0;
        word    = 1'b0;
        use_pc  = 1'b0;
        use_imm = 1'b0;
        has_rs1 = 1'b0;
        has_rs2 = 1'b0;
        has_rd  = 1'b0;
        fmt     = IMM_NONE;
        is_br   = 1'b0;
        is_ld   = 1'b0;
        is_st   = 1'b0;
        case (opc)
            OP, OP_32: begin
                legal   = (f7 == 7'd0 && (opc == OP || f3 inside {3'b000, 3'b001, 3'b101})) ||
                          (f7 == 7'b0100000 && f3 inside {3'b000, 3'b101});
                alu_fn  = f3_fn(f3, ir[30]);
                word    = opc == OP_32;
                has_rs1 = 1'b1;
                has_rs2 = 1'b1;
                has_rd  = 1'b1;
            end
            OP_IMM, OP_IMM_32: begin
                // 64-bit shifts take a 6-bit shamt, word shifts a 5-bit one
                if (f3 == 3'b001)
                    legal = opc == OP_IMM ? ir[31:26] == 6'd0 : f7 == 7'd0;
                else if (f3 == 3'b101)
                    legal = opc == OP_IMM ? {ir[31], ir[29:26]} == 5'd0
                                          : {f7[6], f7[4:0]} == 6'd0;
                else
                    legal = opc == OP_IMM || f3 == 3'b000;
                alu_fn  = f3_fn(f3, f3 == 3'b101 && ir[30]);   // no SUBI
                word    = opc == OP_IMM_32;
                use_imm = 1'b1;
                has_rs1 = 1'b1;
                has_rd  = 1'b1;
                fmt     = IMM_I;
            end
            LUI, AUIPC: begin
                legal   = 1'b1;
                use_pc  = opc == AUIPC;
                use_imm = 1'b1;
                has_rd  = 1'b1;
                fmt     = IMM_U;
            end
            JAL, JALR: begin
                legal   = opc == JAL || f3 == 3'b000;
                fu      = FU_BRANCH;
                use_pc  = 1'b1;         // link value is pc + 4
                has_rs1 = opc == JALR;
                has_rd  = 1'b1;
                fmt     = opc == JAL ? IMM_J : IMM_I;
                is_br   = 1'b1;
            end
            BRANCH: begin
                legal   = f3[2:1] != 2'b01;
                fu      = FU_BRANCH;
                alu_fn  = SUB;          // compare by subtraction
                funct3  = f3;
                has_rs1 = 1'b1;
                has_rs2 = 1'b1;
                fmt     = IMM_B;
                is_br   = 1'b1;
            end
            LOAD: begin
                legal   = f3 != 3'b111;
                fu      = FU_LSU;
                funct3  = f3;
                use_imm = 1'b1;
                has_rs1 = 1'b1;
                has_rd  = 1'b1;
                fmt     = IMM_I;
                is_ld   = 1'b1;
            end
            STORE: begin
                legal   = !f3[2];
                fu      = FU_LSU;
                funct3  = f3;
                use_imm = 1'b1;
                has_rs1 = 1'b1;
                has_rs2 = 1'b1;
                fmt     = IMM_S;
                is_st   = 1'b1;
            end
            MISC_MEM: begin
                legal   = f3 == 3'b000;   // plain fence only
                fu      = FU_LSU;
                funct3  = f3;
                is_st   = 1'b1;           // fence holds a store queue slot
            end
            default: legal = 1'b0;
        endcase

        // unknown opcode, bad function field or compressed encoding
        if (!legal || ir[1:0] != 2'b11) begin
            fu      = FU_INV;
            alu_fn  = ADD;
            funct3  = 3'd0;
            word    = 1'b0;
            use_pc  = 1'b0;
            use_imm = 1'b0;
            has_rs1 = 1'b0;
            has_rs2 = 1'b0;
            has_rd  = 1'b0;
            fmt     = IMM_NONE;
            is_br   = 1'b0;
            is_ld   = 1'b0;
            is_st   = 1'b0;
        end
    end

    assign rs1 = has_rs1 ? ir[19:15] : 5'd0;
    assign rs2 = has_rs2 ? ir[24:20] : 5'd0;
    assign rd  = has_rd  ? ir[11:7]  : 5'd0;

endmodule

//--- design/op_queue.sv
`timescale 1ns/100ps
`include "rv_decode_settings.svh"

module op_queue (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   flush,
    input  logic                   push,
    input  rv_decode_pkg::dec_op_t push_op,
    input  logic                   pop,
    output rv_decode_pkg::dec_op_t head_op,
    output logic                   full,
    output logic                   empty
);
    import rv_decode_pkg::*;

    localparam int PTR_W = $clog2(`QUEUE_DEPTH);

    dec_op_t          mem [`QUEUE_DEPTH];
    logic [PTR_W-1:0] front;
    logic [PTR_W:0]   count;
    logic [PTR_W-1:0] tail;

    assign tail    = front + count[PTR_W-1:0];   // wraps at depth
    assign head_op = mem[front];
    assign full    = count == (PTR_W+1)'(`QUEUE_DEPTH);
    assign empty   = count == '0;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[tail] <= push_op;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            front <= '0;
            count <= '0;
        end else begin
            if (pop) begin
                front <= front + 1'b1;
            end
            count <= count + (PTR_W+1)'(push) - (PTR_W+1)'(pop);
        end
    end

    assert property (@(posedge clk) disable iff (rst) !(push && full))
        else $error("op_queue: push while full");

    assert property (@(posedge clk) disable iff (rst) !(pop && empty))
        else $error("op_queue: pop while empty");

endmodule

//--- design/rv_decode_pkg.sv
`include "rv_decode_settings.svh"

package rv_decode_pkg;

    // major opcode, bits 6:2 of the instruction
    typedef enum logic [4:0] {
        LOAD      = 5'b00000,
        MISC_MEM  = 5'b00011,
        OP_IMM    = 5'b00100,
        AUIPC     = 5'b00101,
        OP_IMM_32 = 5'b00110,
        STORE     = 5'b01000,
        OP        = 5'b01100,
        LUI       = 5'b01101,
        OP_32     = 5'b01110,
        BRANCH    = 5'b11000,
        JALR      = 5'b11001,
        JAL       = 5'b11011
    } opcode_t;

    typedef enum logic [1:0] {
        FU_ALU,
        FU_BRANCH,
        FU_LSU,
        FU_INV      // illegal instruction
    } fu_t;

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND
    } alu_fn_t;

    typedef enum logic [2:0] {
        IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J
    } imm_fmt_t;

    typedef struct packed {
        logic [`XLEN-1:0]              pc;
        fu_t                           fu;
        alu_fn_t                       alu_fn;
        logic [2:0]                    funct3;   // branch condition or memory width
        logic                          word;     // 32-bit op
        logic                          use_pc;
        logic                          use_imm;
        logic [4:0]                    rs1;
        logic [4:0]                    rs2;
        logic [4:0]                    rd;
        logic [`XLEN-1:0]              imm;
        logic [$clog2(`OP_SLOTS)-1:0]  op_id;
        logic [$clog2(`BR_SLOTS)-1:0]  br_id;
        logic [$clog2(`LD_SLOTS)-1:0]  ld_id;
        logic [$clog2(`ST_SLOTS)-1:0]  st_id;
        logic                          is_br;
        logic                          is_ld;
        logic                          is_st;
    } dec_op_t;

endpackage

//--- design/rv_decode_settings.svh
`ifndef RV_DECODE_SETTINGS_SVH
`define RV_DECODE_SETTINGS_SVH

`define XLEN        64  // data width

`define QUEUE_DEPTH 4   // decoded ops waiting for the consumer

// ID pools, all powers of two
`define OP_SLOTS    16  // reorder buffer size
`define BR_SLOTS    4   // branch snapshots
`define LD_SLOTS    8   // load queue entries
`define ST_SLOTS    8   // store queue entries

`endif

//--- design/rv_decode_top.sv
`timescale 1ns/100ps
`include "rv_decode_settings.svh"

module rv_decode_top (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         fetch_valid,
    input  logic [`XLEN-1:0]             fetch_pc,
    input  logic [31:0]                  fetch_ir,
    output logic                         fetch_ready,
    input  logic                         take,
    output logic                         dec_valid,
    output logic [`XLEN-1:0]             dec_pc,
    output rv_decode_pkg::fu_t           dec_fu,
    output rv_decode_pkg::alu_fn_t       dec_alu_fn,
    output logic [2:0]                   dec_funct3,
    output logic                         dec_word,
    output logic                         dec_use_pc,
    output logic                         dec_use_imm,
    output logic [4:0]                   dec_rs1,
    output logic [4:0]                   dec_rs2,
    output logic [4:0]                   dec_rd,
    output logic [`XLEN-1:0]             dec_imm,
    output logic [$clog2(`OP_SLOTS)-1:0] dec_op_id,
    output logic [$clog2(`BR_SLOTS)-1:0] dec_br_id,
    output logic [$clog2(`LD_SLOTS)-1:0] dec_ld_id,
    output logic [$clog2(`ST_SLOTS)-1:0] dec_st_id,
    output logic                         dec_is_br,
    output logic                         dec_is_ld,
    output logic                         dec_is_st,
    input  logic                         commit_valid,
    input  logic                         commit_br,
    input  logic                         commit_ld,
    input  logic                         commit_st,
    input  logic                         redirect,
    input  logic [$clog2(`OP_SLOTS)-1:0] redirect_op_id,
    input  logic [$clog2(`BR_SLOTS)-1:0] redirect_br_id,
    input  logic [$clog2(`LD_SLOTS)-1:0] redirect_ld_id,
    input  logic [$clog2(`ST_SLOTS)-1:0] redirect_st_id
);
    import rv_decode_pkg::*;

    dec_op_t  entry;    // op being accepted this cycle
    dec_op_t  head;
    imm_fmt_t fmt;
    logic     push;
    logic     pop;
    logic     full;
    logic     empty;

    assign entry.pc = fetch_pc;

    inst_classify u_classify (
        .ir(fetch_ir), .fu(entry.fu), .alu_fn(entry.alu_fn), .funct3(entry.funct3),
        .word(entry.word), .use_pc(entry.use_pc), .use_imm(entry.use_imm),
        .rs1(entry.rs1), .rs2(entry.rs2), .rd(entry.rd), .fmt(fmt),
        .is_br(entry.is_br), .is_ld(entry.is_ld), .is_st(entry.is_st)
    );

    imm_extract u_imm (.ir(fetch_ir), .fmt(fmt), .imm(entry.imm));

    id_alloc u_alloc (
        .clk(clk), .rst(rst), .fetch_valid(fetch_valid),
        .is_br(entry.is_br), .is_ld(entry.is_ld), .is_st(entry.is_st), .queue_full(full),
        .commit_valid(commit_valid), .commit_br(commit_br), .commit_ld(commit_ld),
        .commit_st(commit_st), .redirect(redirect), .redirect_op_id(redirect_op_id),
        .redirect_br_id(redirect_br_id), .redirect_ld_id(redirect_ld_id),
        .redirect_st_id(redirect_st_id), .fetch_ready(fetch_ready), .push(push),
        .op_id(entry.op_id), .br_id(entry.br_id), .ld_id(entry.ld_id), .st_id(entry.st_id)
    );

    op_queue u_queue (
        .clk(clk), .rst(rst), .flush(redirect), .push(push), .push_op(entry),
        .pop(pop), .head_op(head), .full(full), .empty(empty)
    );

    assign dec_valid = !empty && !redirect;   // head is stale while flushing
    assign pop       = take && dec_valid;

    assign dec_pc      = head.pc;
    assign dec_fu      = head.fu;
    assign dec_alu_fn  = head.alu_fn;
    assign dec_funct3  = head.funct3;
    assign dec_word    = head.word;
    assign dec_use_pc  = head.use_pc;
    assign dec_use_imm = head.use_imm;
    assign dec_rs1     = head.rs1;
    assign dec_rs2     = head.rs2;
    assign dec_rd      = head.rd;
    assign dec_imm     = head.imm;
    assign dec_op_id   = head.op_id;
    assign dec_br_id   = head.br_id;
    assign dec_ld_id   = head.ld_id;
    assign dec_st_id   = head.st_id;
    assign dec_is_br   = head.is_br;
    assign dec_is_ld   = head.is_ld;
    assign dec_is_st   = head.is_st;

endmodule

//--- filelist.f
+incdir+design
+incdir+tests
design/rv_decode_pkg.sv
design/imm_extract.sv
design/inst_classify.sv
design/id_alloc.sv
design/op_queue.sv
design/rv_decode_top.sv
tests/tb_rv_decode.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f \
    --top-module tb_rv_decode --Mdir obj_dir -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Finished with errors" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "Finished with no errors" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"

//--- tests/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// one decode case: instruction word and the fields it must decode to
typedef struct {
    logic [31:0] ir;
    fu_t         fu;
    alu_fn_t     alu_fn;
    logic [2:0]  funct3;
    logic        word;
    logic        use_pc;
    logic        use_imm;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [63:0] imm;
    logic        is_br;
    logic        is_ld;
    logic        is_st;
} vec_t;

localparam int NUM_VECS = 12;

vec_t vecs [NUM_VECS];

// columns: ir, fu, alu_fn, funct3, word, use_pc, use_imm, rs1, rs2, rd, imm, is_br, is_ld, is_st
task automatic fill_vectors();
    vecs[0]  = '{32'hFFB1_0093, FU_ALU, ADD, 3'd0, 1'b0, 1'b0, 1'b1, 5'd2, 5'd0, 5'd1,
                 64'hFFFF_FFFF_FFFF_FFFB, 1'b0, 1'b0, 1'b0};   // addi x1, x2, -5
    vecs[1]  = '{32'h4052_01B3, FU_ALU, SUB, 3'd0, 1'b0, 1'b0, 1'b0, 5'd4, 5'd5, 5'd3,
                 64'd0, 1'b0, 1'b0, 1'b0};                    // sub x3, x4, x5
    vecs[2]  = '{32'h4083_D33B, FU_ALU, SRA, 3'd0, 1'b1, 1'b0, 1'b0, 5'd7, 5'd8, 5'd6,
                 64'd0, 1'b0, 1'b0, 1'b0};                    // sraw x6, x7, x8
    vecs[3]  = '{32'h0105_2483, FU_LSU, ADD, 3'd2, 1'b0, 1'b0, 1'b1, 5'd10, 5'd0, 5'd9,
                 64'd16, 1'b0, 1'b1, 1'b0};                   // lw x9, 16(x10)
    vecs[4]  = '{32'hFEB6_2C23, FU_LSU, ADD, 3'd2, 1'b0, 1'b0, 1'b1, 5'd12, 5'd11, 5'd0,
                 64'hFFFF_FFFF_FFFF_FFF8, 1'b0, 1'b0, 1'b1};   // sw x11, -8(x12)
    vecs[5]  = '{32'h02E6_8063, FU_BRANCH, SUB, 3'd0, 1'b0, 1'b0, 1'b0, 5'd13, 5'd14, 5'd0,
                 64'd32, 1'b1, 1'b0, 1'b0};                   // beq x13, x14, +32
    vecs[6]  = '{32'h0010_00EF, FU_BRANCH, ADD, 3'd0, 1'b0, 1'b1, 1'b0, 5'd0, 5'd0, 5'd1,
                 64'd2048, 1'b1, 1'b0, 1'b0};                 // jal x1, +2048
    vecs[7]  = '{32'h0040_8067, FU_BRANCH, ADD, 3'd0, 1'b0, 1'b1, 1'b0, 5'd1, 5'd0, 5'd0,
                 64'd4, 1'b1, 1'b0, 1'b0};                    // jalr x0, 4(x1)
    vecs[8]  = '{32'h8000_02B7, FU_ALU, ADD, 3'd0, 1'b0, 1'b0, 1'b1, 5'd0, 5'd0, 5'd5,
                 64'hFFFF_FFFF_8000_0000, 1'b0, 1'b0, 1'b0};   // lui x5, 0x80000
    vecs[9]  = '{32'h1234_5317, FU_ALU, ADD, 3'd0, 1'b0, 1'b1, 1'b1, 5'd0, 5'd0, 5'd6,
                 64'h0000_0000_1234_5000, 1'b0, 1'b0, 1'b0};   // auipc x6, 0x12345
    vecs[10] = '{32'h0FF0_000F, FU_LSU, ADD, 3'd0, 1'b0, 1'b0, 1'b0, 5'd0, 5'd0, 5'd0,
                 64'd0, 1'b0, 1'b0, 1'b1};                    // fence, takes a store slot
    vecs[11] = '{32'hFFFF_FFFF, FU_INV, ADD, 3'd0, 1'b0, 1'b0, 1'b0, 5'd0, 5'd0, 5'd0,
                 64'd0, 1'b0, 1'b0, 1'b0};                    // unknown opcode
endtask

`endif

//--- tests/tb_rv_decode.sv
`timescale 1ns/100ps
`include "rv_decode_settings.svh"

module tb_rv_decode;
    import rv_decode_pkg::*;

    `include "tb_vectors.svh"

    localparam int TIMEOUT = 4 * NUM_VECS + 200;   // cycles
    localparam int BEQ_ROW = 5;

    logic        clk;
    logic        rst;
    logic        fetch_valid;
    logic [63:0] fetch_pc;
    logic [31:0] fetch_ir;
    logic        fetch_ready;
    logic        take;
    logic        dec_valid;
    logic [63:0] dec_pc;
    fu_t         dec_fu;
    alu_fn_t     dec_alu_fn;
    logic [2:0]  dec_funct3;
    logic        dec_word;
    logic        dec_use_pc;
    logic        dec_use_imm;
    logic [4:0]  dec_rs1;
    logic [4:0]  dec_rs2;
    logic [4:0]  dec_rd;
    logic [63:0] dec_imm;
    logic [3:0]  dec_op_id;
    logic [1:0]  dec_br_id;
    logic [2:0]  dec_ld_id;
    logic [2:0]  dec_st_id;
    logic        dec_is_br;
    logic        dec_is_ld;
    logic        dec_is_st;
    logic        commit_valid;
    logic        commit_br;
    logic        commit_ld;
    logic        commit_st;
    logic        redirect;
    logic [3:0]  redirect_op_id;
    logic [1:0]  redirect_br_id;
    logic [2:0]  redirect_ld_id;
    logic [2:0]  redirect_st_id;

    int          errors;
    int          cycles;
    int          seed;
    // next IDs the stage should hand out
    logic [3:0]  exp_op;
    logic [1:0]  exp_br;
    logic [2:0]  exp_ld;
    logic [2:0]  exp_st;
    // accepted ops not yet seen at the output
    int          q_idx [$];
    logic [63:0] q_pc [$];
    logic [3:0]  q_op [$];
    logic [1:0]  q_br [$];
    logic [2:0]  q_ld [$];
    logic [2:0]  q_st [$];

    rv_decode_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT);
            $display("Finished with errors");
            $finish;
        end
    end

    task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
        assert (act === exp) else begin
            $display("ERR %0t %s expected %0h actual %0h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            $display("%0t: %s", $time, what);
            errors++;
        end
    endtask

    // drive one row until accepted, recording the IDs it should carry
    task automatic send(input int idx, input logic [63:0] pc);
        @(negedge clk);
        fetch_valid = 1'b1;
        fetch_ir    = vecs[idx].ir;
        fetch_pc    = pc;
        #1;
        while (!fetch_ready) begin
            @(negedge clk);
            #1;
        end
        @(posedge clk);
        q_idx.push_back(idx);
        q_pc.push_back(pc);
        q_op.push_back(exp_op);
        q_br.push_back(exp_br);
        q_ld.push_back(exp_ld);
        q_st.push_back(exp_st);
        exp_op++;
        if (vecs[idx].is_br) exp_br++;
        if (vecs[idx].is_ld) exp_ld++;
        if (vecs[idx].is_st) exp_st++;
        @(negedge clk);
        fetch_valid = 1'b0;
    endtask

    // called on a falling edge; takes the head and compares it with the oldest record
    task automatic receive();
        vec_t v;
        take = 1'b1;
        while (!dec_valid) @(negedge clk);
        if (q_idx.size() == 0) begin
            check_true(1'b0, "output appeared with no accepted instruction left");
        end else begin
            v = vecs[q_idx.pop_front()];
            check_val("dec_pc", q_pc.pop_front(), dec_pc);
            check_val("dec_fu", 64'(v.fu), 64'(dec_fu));
            check_val("dec_alu_fn", 64'(v.alu_fn), 64'(dec_alu_fn));
            check_val("dec_funct3", 64'(v.funct3), 64'(dec_funct3));
            check_val("dec_word", 64'(v.word), 64'(dec_word));
            check_val("dec_use_pc", 64'(v.use_pc), 64'(dec_use_pc));
            check_val("dec_use_imm", 64'(v.use_imm), 64'(dec_use_imm));
            check_val("dec_rs1", 64'(v.rs1), 64'(dec_rs1));
            check_val("dec_rs2", 64'(v.rs2), 64'(dec_rs2));
            check_val("dec_rd", 64'(v.rd), 64'(dec_rd));
            check_val("dec_imm", v.imm, dec_imm);
            check_val("dec_is_br", 64'(v.is_br), 64'(dec_is_br));
            check_val("dec_is_ld", 64'(v.is_ld), 64'(dec_is_ld));
            check_val("dec_is_st", 64'(v.is_st), 64'(dec_is_st));
            // every op carries the current next ID of all pools
            check_val("dec_op_id", 64'(q_op.pop_front()), 64'(dec_op_id));
            check_val("dec_br_id", 64'(q_br.pop_front()), 64'(dec_br_id));
            check_val("dec_ld_id", 64'(q_ld.pop_front()), 64'(dec_ld_id));
            check_val("dec_st_id", 64'(q_st.pop_front()), 64'(dec_st_id));
        end
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic commit_row(input int idx);
        commit_valid = 1'b1;
        commit_br    = vecs[idx].is_br;
        commit_ld    = vecs[idx].is_ld;
        commit_st    = vecs[idx].is_st;
        @(negedge clk);
        commit_valid = 1'b0;
        commit_br    = 1'b0;
        commit_ld    = 1'b0;
        commit_st    = 1'b0;
    endtask

    initial begin
        logic [63:0] pc;
        logic [3:0]  r_op;
        logic [1:0]  r_br;
        logic [2:0]  r_ld;
        logic [2:0]  r_st;

        errors = 0;
        cycles = 0;
        seed   = 21;
        exp_op = '0;
        exp_br = '0;
        exp_ld = '0;
        exp_st = '0;
        rst = 1'b1;
        fetch_valid = 1'b0;
        fetch_pc = '0;
        fetch_ir = '0;
        take = 1'b1;
        commit_valid = 1'b0;
        commit_br = 1'b0;
        commit_ld = 1'b0;
        commit_st = 1'b0;
        redirect = 1'b0;
        redirect_op_id = '0;
        redirect_br_id = '0;
        redirect_ld_id = '0;
        redirect_st_id = '0;
        fill_vectors();

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #1;
        check_true(fetch_ready, "fetch_ready low after reset");
        check_true(!dec_valid, "dec_valid high after reset");

        // decode table, one op at a time, each committed after it leaves
        for (int i = 0; i < NUM_VECS; i++) begin
            pc = {$random(seed), $random(seed)} & ~64'd3;
            send(i, pc);
            receive();
            commit_row(i);
        end

        // back-pressure: the queue fills, then drains in order
        take = 1'b0;
        for (int i = 0; i < `QUEUE_DEPTH; i++) begin
            send(i, 64'h1000 + 64'(4 * i));
        end
        fetch_valid = 1'b1;
        fetch_ir    = vecs[0].ir;
        #1;
        check_true(!fetch_ready, "fetch_ready high with the queue full");
        @(negedge clk);
        fetch_valid = 1'b0;
        for (int i = 0; i < `QUEUE_DEPTH; i++) begin
            receive();
        end
        for (int i = 0; i < `QUEUE_DEPTH; i++) begin
            commit_row(i);
        end

        // branch pool: four branches fill it, the fifth waits for a commit
        for (int i = 0; i < `BR_SLOTS; i++) begin
            send(BEQ_ROW, 64'h2000 + 64'(4 * i));
            receive();
        end
        fetch_ir = vecs[BEQ_ROW].ir;
        #1;
        check_true(!fetch_ready, "fifth branch accepted with the branch pool full");
        @(negedge clk);
        commit_row(BEQ_ROW);
        #1;
        check_true(fetch_ready, "branch stall did not clear after a branch commit");
        send(BEQ_ROW, 64'h2010);
        receive();
        for (int i = 0; i < `BR_SLOTS; i++) begin
            commit_row(BEQ_ROW);
        end

        // redirect on the queued branch flushes it and the load behind it
        take = 1'b0;
        send(BEQ_ROW, 64'h3000);
        send(3, 64'h3004);
        r_op = q_op[0];
        r_br = exp_br;
        r_ld = q_ld[1];
        r_st = exp_st;
        redirect       = 1'b1;
        redirect_op_id = r_op;
        redirect_br_id = r_br;
        redirect_ld_id = r_ld;
        redirect_st_id = r_st;
        #1;
        check_true(!dec_valid, "dec_valid high during redirect");
        @(negedge clk);
        redirect = 1'b0;
        #1;
        check_true(!dec_valid, "queue not empty after redirect");
        q_idx.delete();
        q_pc.delete();
        q_op.delete();
        q_br.delete();
        q_ld.delete();
        q_st.delete();
        exp_op = r_op + 4'd1;
        exp_br = r_br;
        exp_ld = r_ld;
        exp_st = r_st;
        send(0, 64'h4000);
        receive();
        commit_row(BEQ_ROW);   // the redirecting branch
        commit_row(0);

        $display("decode test done, errors: %0d", errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
